/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --assert --timing -Wno-fatal
TOP := tb_frost_cpu
FILELIST := compile.f
SRCS := $(shell cat $(FILELIST))
BIN := obj_dir/V$(TOP)
LOG := sim.log

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* alu.sv */
`timescale 1ns/1ps

module alu (
	input logic [frost_bus_pkg::DATA_W-1:0] a,
	input logic [frost_bus_pkg::DATA_W-1:0] b,
	input frost_isa_pkg::alu_op_t op,
	output logic [frost_bus_pkg::DATA_W-1:0] y
);

	// shift amount, low bits of b only
	localparam int unsigned SHAMT_W = $clog2(frost_bus_pkg::DATA_W);

	logic [SHAMT_W-1:0] shamt;

	assign shamt = b[SHAMT_W-1:0];

	always_comb
	begin
		case (op)
			frost_isa_pkg::ALU_ADD:
				y = a + b;
			frost_isa_pkg::ALU_SUB:
				y = a - b;
			frost_isa_pkg::ALU_AND:
				y = a & b;
			frost_isa_pkg::ALU_OR:
				y = a | b;
			frost_isa_pkg::ALU_XOR:
				y = a ^ b;
			frost_isa_pkg::ALU_SLL:
				y = a << shamt;
			frost_isa_pkg::ALU_SRL:
				y = a >> shamt;
			// signed less-than, result is 1 or 0
			frost_isa_pkg::ALU_SLTS:
				y = {{(frost_bus_pkg::DATA_W - 1){1'b0}}, $signed(a) < $signed(b)};
			default:
				y = '0;
		endcase
	end

endmodule

/* compile.f */
frost_isa_pkg.sv
frost_bus_pkg.sv
instr_decoder.sv
register_file.sv
alu.sv
fetch_control.sv
execute_stage.sv
frost_cpu.sv
frost_cpu_assertions.sv
tb_frost_cpu.sv

/* execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
	input logic clk,
	input logic rst_n,
	input frost_isa_pkg::decoded_t dec_q,
	input logic [frost_bus_pkg::DATA_W-1:0] data_ra,
	input logic [frost_bus_pkg::DATA_W-1:0] data_rb,
	input logic [frost_bus_pkg::DATA_W-1:0] data_rc,
	input logic [frost_bus_pkg::DATA_W-1:0] alu_y,
	output logic [frost_bus_pkg::DATA_W-1:0] alu_a,
	output logic [frost_bus_pkg::DATA_W-1:0] alu_b,
	output frost_isa_pkg::alu_op_t alu_op,
	output logic [frost_bus_pkg::DATA_W-1:0] next_pc,
	output frost_bus_pkg::wb_req_t wb
);

	localparam int unsigned EXT_W = frost_bus_pkg::DATA_W - frost_isa_pkg::IMM_W;

	logic [frost_bus_pkg::DATA_W-1:0] imm_zext;
	logic [frost_bus_pkg::DATA_W-1:0] imm_sext;
	logic [frost_bus_pkg::DATA_W-1:0] pc_plus4;
	logic [frost_bus_pkg::DATA_W-1:0] next_pc_d;
	logic regs_equal;
	logic jump_taken;
	frost_bus_pkg::wb_req_t wb_d;

	assign imm_zext = {{EXT_W{1'b0}}, dec_q.imm};
	assign imm_sext = {{EXT_W{dec_q.imm[frost_isa_pkg::IMM_W-1]}}, dec_q.imm};
	assign pc_plus4 = dec_q.pc + frost_bus_pkg::DATA_W'(frost_isa_pkg::INSTR_BYTES);
	// every condition compares ra with rb
	assign regs_equal = (data_ra == data_rb);
	assign jump_taken = ((dec_q.opcode == frost_isa_pkg::OP_JNE)
		|| (dec_q.opcode == frost_isa_pkg::OP_CALLNE)) ? !regs_equal : regs_equal;

	// alu operands, rb+rc add unless the group says otherwise
	always_comb
	begin
		alu_a = data_rb;
		alu_b = data_rc;
		alu_op = frost_isa_pkg::ALU_ADD;
		case (dec_q.group)
			frost_isa_pkg::GRP_ALU:
				alu_op = frost_isa_pkg::alu_op_t'(dec_q.opcode);
			frost_isa_pkg::GRP_IMM:
			begin
				alu_b = imm_zext;
				case (dec_q.opcode)
					frost_isa_pkg::OP_ORI:
						alu_op = frost_isa_pkg::ALU_OR;
					frost_isa_pkg::OP_SLTSI:
					begin
						alu_b = imm_sext;
						alu_op = frost_isa_pkg::ALU_SLTS;
					end
					frost_isa_pkg::OP_ADDSI:
					begin
						alu_a = dec_q.pc;
						alu_b = imm_sext;
					end
					// branch target is relative to the next pc
					frost_isa_pkg::OP_BNE,
					frost_isa_pkg::OP_BEQ:
					begin
						alu_a = pc_plus4;
						alu_b = imm_sext;
					end
					default:
						alu_op = frost_isa_pkg::ALU_ADD;
				endcase
			end
			default:
				alu_op = frost_isa_pkg::ALU_ADD;
		endcase
	end

	// write-back request and redirect target
	always_comb
	begin
		wb_d.en = 1'b0;
		wb_d.sel = dec_q.ra;
		wb_d.data = alu_y;
		next_pc_d = pc_plus4;
		case (dec_q.group)
			frost_isa_pkg::GRP_ALU:
				wb_d.en = 1'b1;
			frost_isa_pkg::GRP_IMM:
				case (dec_q.opcode)
					frost_isa_pkg::OP_ADDI,
					frost_isa_pkg::OP_ORI,
					frost_isa_pkg::OP_SLTSI,
					frost_isa_pkg::OP_ADDSI:
						wb_d.en = 1'b1;
					frost_isa_pkg::OP_CPYHI:
					begin
						// immediate becomes the upper half, lower half of ra stays
						wb_d.en = 1'b1;
						wb_d.data = {dec_q.imm, data_ra[EXT_W-1:0]};
					end
					frost_isa_pkg::OP_BNE:
						if (!regs_equal)
							next_pc_d = alu_y;
					frost_isa_pkg::OP_BEQ:
						if (regs_equal)
							next_pc_d = alu_y;
					default:
						wb_d.en = 1'b0;
				endcase
			frost_isa_pkg::GRP_JUMP:
				case (dec_q.opcode)
					frost_isa_pkg::OP_JNE,
					frost_isa_pkg::OP_JEQ:
						if (jump_taken)
							next_pc_d = data_rc;
					frost_isa_pkg::OP_CALLNE,
					frost_isa_pkg::OP_CALLEQ:
						if (jump_taken)
						begin
							// link goes to ra only when the call is taken
							next_pc_d = data_rc;
							wb_d.en = 1'b1;
							wb_d.data = pc_plus4;
						end
					default:
						wb_d.en = 1'b0;
				endcase
			default:
				wb_d.en = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			wb.en <= 1'b0;
		else
			wb <= wb_d;
	end

	// bubbles behind a stalling instruction must not move the target
	always_ff @(posedge clk)
	begin
		if (dec_q.causes_stall)
			next_pc <= next_pc_d;
	end

endmodule

/* fetch_control.sv */
`timescale 1ns/1ps

module fetch_control #(
	parameter logic [frost_bus_pkg::ADDR_W-1:0] RESET_VECTOR = '0
) (
	input logic clk,
	input logic rst_n,
	input logic [frost_isa_pkg::INSTR_W-1:0] mem_rdata,
	input logic [frost_bus_pkg::DATA_W-1:0] next_pc,
	input logic [frost_bus_pkg::DATA_W-1:0] alu_y,
	input logic [frost_bus_pkg::DATA_W-1:0] store_data,
	output frost_bus_pkg::mem_req_t mem,
	output logic [frost_isa_pkg::REG_SEL_W-1:0] sel_ra,
	output logic [frost_isa_pkg::REG_SEL_W-1:0] sel_rb,
	output logic [frost_isa_pkg::REG_SEL_W-1:0] sel_rc,
	output frost_isa_pkg::decoded_t dec_q
);

	localparam int unsigned CNT_W = $clog2(frost_isa_pkg::STALL_CYCLES + 1);
	localparam logic [CNT_W-1:0] CNT_STORE = CNT_W'(frost_isa_pkg::STALL_CYCLES);
	localparam logic [CNT_W-1:0] CNT_REDIRECT = CNT_W'(1);

	// address of the instruction now on mem_rdata
	logic [frost_bus_pkg::ADDR_W-1:0] pc;
	logic [frost_bus_pkg::ADDR_W-1:0] pc_seq;
	logic [CNT_W-1:0] stall_cnt;
	// a fetch went out last cycle, so mem_rdata holds an instruction
	logic rdata_valid;
	logic issue;
	frost_isa_pkg::decoded_t dec;

	instr_decoder u_decoder (
		.instr(mem_rdata),
		.pc(pc),
		.dec(dec)
	);

	assign pc_seq = pc + frost_bus_pkg::ADDR_W'(frost_isa_pkg::INSTR_BYTES);
	assign issue = rdata_valid && (stall_cnt == '0);

	// read selects go out with the instruction, zero for a bubble
	assign sel_ra = issue ? dec.ra : '0;
	assign sel_rb = issue ? dec.rb : '0;
	assign sel_rc = issue ? dec.rc : '0;

	// single owner of the memory port
	always_comb
	begin
		mem = '0;
		if (stall_cnt == CNT_STORE)
		begin
			// store sits in execute, address is rb+rc from the alu
			if (dec_q.group == frost_isa_pkg::GRP_STORE)
			begin
				mem.req = 1'b1;
				mem.write = 1'b1;
				mem.addr = alu_y;
				mem.wdata = store_data;
			end
		end
		else if (stall_cnt == CNT_REDIRECT)
		begin
			// resolved target from execute
			mem.req = 1'b1;
			mem.addr = next_pc;
		end
		else if (stall_cnt == '0)
		begin
			if (!rdata_valid)
			begin
				// first fetch out of reset
				mem.req = 1'b1;
				mem.addr = pc;
			end
			else if (!dec.causes_stall)
			begin
				mem.req = 1'b1;
				mem.addr = pc_seq;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			pc <= RESET_VECTOR;
			stall_cnt <= '0;
			rdata_valid <= 1'b0;
			dec_q <= '0;
		end
		else
		begin
			rdata_valid <= mem.req && !mem.write;
			if (issue)
			begin
				dec_q <= dec;
				// pc holds for a stalling instruction until the redirect
				if (dec.causes_stall)
					stall_cnt <= CNT_STORE;
				else
					pc <= pc_seq;
			end
			else
			begin
				// all-zero word is add r0, r0, r0
				dec_q <= '0;
				if (stall_cnt != '0)
					stall_cnt <= stall_cnt - CNT_W'(1);
				if (stall_cnt == CNT_REDIRECT)
					pc <= next_pc;
			end
		end
	end

endmodule

/* frost_bus_pkg.sv */
package frost_bus_pkg;

	// address bus follows the program counter
	localparam int unsigned ADDR_W = frost_isa_pkg::PC_W;
	localparam int unsigned DATA_W = 32;

	// shared memory port, one request per cycle
	// write low is an instruction fetch, answered one cycle later
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic write;
		logic req;
	} mem_req_t;

	// register file write request from execute
	typedef struct packed {
		logic en;
		logic [frost_isa_pkg::REG_SEL_W-1:0] sel;
		logic [DATA_W-1:0] data;
	} wb_req_t;

endpackage

/* frost_cpu.sv */
`timescale 1ns/1ps

module frost_cpu #(
	parameter logic [frost_bus_pkg::ADDR_W-1:0] RESET_VECTOR = '0
) (
	input logic clk,
	input logic rst_n,
	input logic [frost_isa_pkg::INSTR_W-1:0] mem_rdata,
	output frost_bus_pkg::mem_req_t mem
);

	// decode to execute
	frost_isa_pkg::decoded_t dec_q;
	logic [frost_isa_pkg::REG_SEL_W-1:0] sel_ra;
	logic [frost_isa_pkg::REG_SEL_W-1:0] sel_rb;
	logic [frost_isa_pkg::REG_SEL_W-1:0] sel_rc;
	logic [frost_bus_pkg::DATA_W-1:0] data_ra;
	logic [frost_bus_pkg::DATA_W-1:0] data_rb;
	logic [frost_bus_pkg::DATA_W-1:0] data_rc;
	// alu between execute and fetch, its result also feeds the store address
	logic [frost_bus_pkg::DATA_W-1:0] alu_a;
	logic [frost_bus_pkg::DATA_W-1:0] alu_b;
	logic [frost_bus_pkg::DATA_W-1:0] alu_y;
	frost_isa_pkg::alu_op_t alu_op;
	// execute back to fetch and the register file
	logic [frost_bus_pkg::DATA_W-1:0] next_pc;
	frost_bus_pkg::wb_req_t wb;

	fetch_control #(
		.RESET_VECTOR(RESET_VECTOR)
	) u_fetch (
		.clk(clk),
		.rst_n(rst_n),
		.mem_rdata(mem_rdata),
		.next_pc(next_pc),
		.alu_y(alu_y),
		.store_data(data_ra),
		.mem(mem),
		.sel_ra(sel_ra),
		.sel_rb(sel_rb),
		.sel_rc(sel_rc),
		.dec_q(dec_q)
	);

	execute_stage u_execute (
		.clk(clk),
		.rst_n(rst_n),
		.dec_q(dec_q),
		.data_ra(data_ra),
		.data_rb(data_rb),
		.data_rc(data_rc),
		.alu_y(alu_y),
		.alu_a(alu_a),
		.alu_b(alu_b),
		.alu_op(alu_op),
		.next_pc(next_pc),
		.wb(wb)
	);

	register_file u_regs (
		.clk(clk),
		.rst_n(rst_n),
		.sel_ra(sel_ra),
		.sel_rb(sel_rb),
		.sel_rc(sel_rc),
		.wb(wb),
		.data_ra(data_ra),
		.data_rb(data_rb),
		.data_rc(data_rc)
	);

	alu u_alu (
		.a(alu_a),
		.b(alu_b),
		.op(alu_op),
		.y(alu_y)
	);

endmodule

/* frost_cpu_assertions.sv */
`timescale 1ns/1ps

module frost_cpu_assertions #(
	parameter logic [31:0] RESET_VECTOR = '0
) (
	input logic clk,
	input logic rst_n,
	input frost_bus_pkg::mem_req_t mem,
	input frost_isa_pkg::decoded_t dec_q
);

	// pc of the last stalling instruction seen in execute
	logic [31:0] stall_pc;
	// its word index into the redirect table
	logic [8:0] stall_off;
	logic [5:0] slot;
	// address on the port one cycle earlier
	logic [31:0] prev_addr;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			stall_pc <= RESET_VECTOR;
		else if (dec_q.causes_stall)
			stall_pc <= dec_q.pc;
	end

	always_ff @(posedge clk)
		prev_addr <= mem.addr;

	assign stall_off = 9'((stall_pc - RESET_VECTOR) >> 2);
	assign slot = mem.addr[7:2];

	// first cycle out of reset fetches the reset vector
	reset_fetch: assert property (@(posedge clk)
		$rose(rst_n) |-> (mem.req && !mem.write && mem.addr == RESET_VECTOR))
		else
		begin
			tb_frost_cpu.assert_count++;
			$error("first fetch after reset is not at the reset vector");
		end

	// back-to-back fetches step by one word
	seq_fetch: assert property (@(posedge clk) disable iff (!rst_n)
		(mem.req && !mem.write && $past(mem.req && !mem.write) && $past(rst_n))
		|-> (mem.addr == prev_addr + 32'd4))
		else
		begin
			tb_frost_cpu.assert_count++;
			$error("mismatch mem.addr %h expected %h", $sampled(mem.addr),
				$sampled(prev_addr) + 32'd4);
		end

	// a fetch after an idle cycle is the redirect of a stalling instruction
	redirect_fetch: assert property (@(posedge clk) disable iff (!rst_n)
		(mem.req && !mem.write && !$past(mem.req) && $past(rst_n))
		|-> (mem.addr == tb_frost_cpu.redirect_tbl[stall_off]))
		else
		begin
			tb_frost_cpu.assert_count++;
			$error("mismatch mem.addr %h expected %h", $sampled(mem.addr),
				tb_frost_cpu.redirect_tbl[$sampled(stall_off)]);
		end

	store_addr: assert property (@(posedge clk) disable iff (!rst_n)
		(mem.req && mem.write)
		|-> (mem.addr[31:8] == 24'h10 && mem.addr[1:0] == 2'b00 && tb_frost_cpu.exp_valid[slot]))
		else
		begin
			tb_frost_cpu.assert_count++;
			$error("store to an address the program does not name");
		end

	store_data: assert property (@(posedge clk) disable iff (!rst_n)
		(mem.req && mem.write && mem.addr[31:8] == 24'h10 && tb_frost_cpu.exp_valid[slot])
		|-> (mem.wdata == tb_frost_cpu.exp_store[slot]))
		else
		begin
			tb_frost_cpu.assert_count++;
			$error("mismatch mem.wdata %h expected %h", $sampled(mem.wdata),
				tb_frost_cpu.exp_store[$sampled(slot)]);
		end

endmodule

/* frost_isa_pkg.sv */
package frost_isa_pkg;

	// instruction word and field widths
	localparam int unsigned INSTR_W = 32;
	localparam int unsigned REG_SEL_W = 4;
	localparam int unsigned IMM_W = 16;
	// program counter width, the address bus is sized from it
	localparam int unsigned PC_W = 32;

	// lsb of each field in the instruction word
	localparam int unsigned GROUP_LSB = 28;
	localparam int unsigned OPCODE_LSB = 24;
	localparam int unsigned RA_LSB = 20;
	localparam int unsigned RB_LSB = 16;
	localparam int unsigned RC_LSB = 12;
	// rc and the immediate overlap
	localparam int unsigned IMM_LSB = 0;

	// cycles that decode holds after a control-flow or store instruction
	localparam int unsigned STALL_CYCLES = 3;
	localparam int unsigned INSTR_BYTES = 4;

	typedef logic [3:0] instr_group_t;
	typedef logic [3:0] opcode_t;

	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_AND = 4'd2,
		ALU_OR = 4'd3,
		ALU_XOR = 4'd4,
		ALU_SLL = 4'd5,
		ALU_SRL = 4'd6,
		ALU_SLTS = 4'd7
	} alu_op_t;

	localparam instr_group_t GRP_ALU = 4'd0;
	localparam instr_group_t GRP_IMM = 4'd1;
	localparam instr_group_t GRP_JUMP = 4'd2;
	localparam instr_group_t GRP_STORE = 4'd3;

	// group 0, opcode is the alu operation itself
	localparam opcode_t OP_ADD = opcode_t'(ALU_ADD);
	localparam opcode_t OP_SUB = opcode_t'(ALU_SUB);
	localparam opcode_t OP_AND = opcode_t'(ALU_AND);
	localparam opcode_t OP_OR = opcode_t'(ALU_OR);
	localparam opcode_t OP_XOR = opcode_t'(ALU_XOR);
	localparam opcode_t OP_SLL = opcode_t'(ALU_SLL);
	localparam opcode_t OP_SRL = opcode_t'(ALU_SRL);
	localparam opcode_t OP_SLTS = opcode_t'(ALU_SLTS);

	// group 1
	localparam opcode_t OP_ADDI = 4'd0;
	localparam opcode_t OP_ORI = 4'd1;
	localparam opcode_t OP_SLTSI = 4'd2;
	localparam opcode_t OP_ADDSI = 4'd3;
	localparam opcode_t OP_CPYHI = 4'd4;
	localparam opcode_t OP_BNE = 4'd5;
	localparam opcode_t OP_BEQ = 4'd6;

	// group 2
	localparam opcode_t OP_JNE = 4'd0;
	localparam opcode_t OP_JEQ = 4'd1;
	localparam opcode_t OP_CALLNE = 4'd2;
	localparam opcode_t OP_CALLEQ = 4'd3;

	// group 3
	localparam opcode_t OP_ST32 = 4'd0;

	// decode register contents, handed from decode to execute
	typedef struct packed {
		instr_group_t group;
		opcode_t opcode;
		logic [REG_SEL_W-1:0] ra;
		logic [REG_SEL_W-1:0] rb;
		logic [REG_SEL_W-1:0] rc;
		logic [IMM_W-1:0] imm;
		logic causes_stall;
		logic [PC_W-1:0] pc;
	} decoded_t;

endpackage

/* instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
	input logic [frost_isa_pkg::INSTR_W-1:0] instr,
	input logic [frost_bus_pkg::ADDR_W-1:0] pc,
	output frost_isa_pkg::decoded_t dec
);

	always_comb
	begin
		// plain field slicing
		dec.group = instr[frost_isa_pkg::GROUP_LSB +: $bits(frost_isa_pkg::instr_group_t)];
		dec.opcode = instr[frost_isa_pkg::OPCODE_LSB +: $bits(frost_isa_pkg::opcode_t)];
		dec.ra = instr[frost_isa_pkg::RA_LSB +: frost_isa_pkg::REG_SEL_W];
		dec.rb = instr[frost_isa_pkg::RB_LSB +: frost_isa_pkg::REG_SEL_W];
		dec.rc = instr[frost_isa_pkg::RC_LSB +: frost_isa_pkg::REG_SEL_W];
		dec.imm = instr[frost_isa_pkg::IMM_LSB +: frost_isa_pkg::IMM_W];
		// address of this instruction, used by addsi and the branch targets
		dec.pc = pc;

		// jumps, calls and stores always stall
		// in group 1 only the two branches do
		case (dec.group)
			frost_isa_pkg::GRP_JUMP,
			frost_isa_pkg::GRP_STORE:
				dec.causes_stall = 1'b1;
			frost_isa_pkg::GRP_IMM:
				dec.causes_stall = (dec.opcode == frost_isa_pkg::OP_BNE)
					|| (dec.opcode == frost_isa_pkg::OP_BEQ);
			default:
				dec.causes_stall = 1'b0;
		endcase
	end

endmodule

/* register_file.sv */
`timescale 1ns/1ps

module register_file (
	input logic clk,
	input logic rst_n,
	input logic [frost_isa_pkg::REG_SEL_W-1:0] sel_ra,
	input logic [frost_isa_pkg::REG_SEL_W-1:0] sel_rb,
	input logic [frost_isa_pkg::REG_SEL_W-1:0] sel_rc,
	input frost_bus_pkg::wb_req_t wb,
	output logic [frost_bus_pkg::DATA_W-1:0] data_ra,
	output logic [frost_bus_pkg::DATA_W-1:0] data_rb,
	output logic [frost_bus_pkg::DATA_W-1:0] data_rc
);

	localparam int unsigned NUM_REGS = 2 ** frost_isa_pkg::REG_SEL_W;

	logic [frost_bus_pkg::DATA_W-1:0] regs [NUM_REGS];
	// selects captured at the edge, so the data lines up with the decode register
	logic [frost_isa_pkg::REG_SEL_W-1:0] sel_ra_q;
	logic [frost_isa_pkg::REG_SEL_W-1:0] sel_rb_q;
	logic [frost_isa_pkg::REG_SEL_W-1:0] sel_rc_q;

	// r0 reads as zero whatever the array holds
	function automatic logic [frost_bus_pkg::DATA_W-1:0] read_reg(
		input logic [frost_isa_pkg::REG_SEL_W-1:0] sel
	);
		return (sel == '0) ? '0 : regs[sel];
	endfunction

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			sel_ra_q <= '0;
			sel_rb_q <= '0;
			sel_rc_q <= '0;
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end
		else
		begin
			sel_ra_q <= sel_ra;
			sel_rb_q <= sel_rb;
			sel_rc_q <= sel_rc;
			// writes to r0 are dropped, bubbles rely on this
			if (wb.en && (wb.sel != '0))
				regs[wb.sel] <= wb.data;
		end
	end

	assign data_ra = read_reg(sel_ra_q);
	assign data_rb = read_reg(sel_rb_q);
	assign data_rc = read_reg(sel_rc_q);

endmodule

/* tb_frost_cpu.sv */
`timescale 1ns/1ps

module tb_frost_cpu;

	localparam logic [31:0] RESET_VECTOR = 32'h0;
	localparam logic [31:0] STORE_BASE = 32'h1000;
	localparam int PROG_WORDS = 512;
	localparam int SLOTS = 64;
	localparam int TIMEOUT = 20000;

	logic clk;
	logic rst_n;
	logic [31:0] mem_rdata = '0;
	frost_bus_pkg::mem_req_t mem;

	logic [31:0] prog [PROG_WORDS];
	logic [31:0] redirect_tbl [PROG_WORDS];
	logic [31:0] exp_store [SLOTS];
	logic exp_valid [SLOTS];
	logic seen [SLOTS];
	logic [31:0] model [16];
	logic [31:0] pc_emit;
	logic [31:0] rng;
	int prog_len;
	int next_slot;
	int done_slot;
	int mismatch_count;
	int assert_count;
	int other_count;

	frost_cpu #(
		.RESET_VECTOR(RESET_VECTOR)
	) dut (
		.clk(clk),
		.rst_n(rst_n),
		.mem_rdata(mem_rdata),
		.mem(mem)
	);

	bind frost_cpu frost_cpu_assertions #(
		.RESET_VECTOR(RESET_VECTOR)
	) u_checks (
		.clk(clk),
		.rst_n(rst_n),
		.mem(mem),
		.dec_q(dec_q)
	);

	initial
		clk = 1'b0;
	always #5 clk = ~clk;

	// memory answers a read one cycle later and records stores
	always @(posedge clk)
	begin
		int idx;
		int slot;
		if (mem.req && !mem.write)
		begin
			idx = int'((mem.addr - RESET_VECTOR) >> 2);
			if (idx < 0 || idx >= prog_len)
			begin
				other_count++;
				$display("fetch outside the program at %h", mem.addr);
				mem_rdata <= '0;
			end
			else
				mem_rdata <= prog[idx];
		end
		else if (mem.req && mem.write)
		begin
			slot = int'(mem.addr[7:2]);
			if (mem.addr[31:8] != STORE_BASE[31:8] || !exp_valid[slot])
			begin
				other_count++;
				$display("store to unexpected address %h", mem.addr);
			end
			else
			begin
				seen[slot] = 1'b1;
				if (mem.wdata != exp_store[slot])
				begin
					mismatch_count++;
					$display("mismatch mem.wdata at %h: got %h expected %h",
						mem.addr, mem.wdata, exp_store[slot]);
				end
			end
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] encode(input logic [3:0] g, input logic [3:0] op,
		input logic [3:0] ra, input logic [3:0] rb, input logic [15:0] low);
		return {g, op, ra, rb, low};
	endfunction

	function automatic logic [31:0] sext16(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	// reference results written from the instruction descriptions
	function automatic logic [31:0] expected_alu(input int op, input logic [31:0] a,
		input logic [31:0] b);
		case (op)
			0: return a + b;
			1: return a - b;
			2: return a & b;
			3: return a | b;
			4: return a ^ b;
			5: return a << b[4:0];
			6: return a >> b[4:0];
			default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		endcase
	endfunction

	task automatic emit(input logic [31:0] word);
		prog[prog_len] = word;
		prog_len++;
		pc_emit += 32'd4;
	endtask

	// two nops keep the next reader clear of the missing forwarding
	task automatic emit_spaced(input logic [31:0] word);
		emit(word);
		emit(32'h0);
		emit(32'h0);
	endtask

	task automatic set_reg(input logic [3:0] r, input logic [15:0] v);
		emit_spaced(encode(4'd1, frost_isa_pkg::OP_ADDI, r, 4'd0, v));
		model[r] = {16'h0, v};
	endtask

	// addi for the low half, then cpyhi for the high half
	task automatic load_reg(input logic [3:0] r, input logic [31:0] v);
		set_reg(r, v[15:0]);
		emit_spaced(encode(4'd1, frost_isa_pkg::OP_CPYHI, r, 4'd0, v[31:16]));
		model[r] = v;
	endtask

	task automatic store_reg(input logic [3:0] r);
		logic [31:0] p;
		set_reg(4'd14, 16'(next_slot * 4));
		p = pc_emit;
		emit_spaced(encode(4'd3, frost_isa_pkg::OP_ST32, r, 4'd13, {4'd14, 12'h0}));
		redirect_tbl[(p - RESET_VECTOR) >> 2] = p + 32'd4;
		exp_store[next_slot] = model[r];
		exp_valid[next_slot] = 1'b1;
		next_slot++;
	endtask

	// r5 counts the fall-through block, so its stored value shows the path taken
	task automatic cond_flow(input logic [3:0] g, input logic [3:0] op,
		input logic [3:0] ra, input logic [3:0] rb);
		logic [31:0] p;
		logic [31:0] target;
		logic ne;
		logic taken;
		logic is_call;
		set_reg(4'd5, 16'h0);
		if (g == frost_isa_pkg::GRP_JUMP)
			set_reg(4'd6, 16'(pc_emit + 32'd12 + 32'd16));
		p = pc_emit;
		target = p + 32'd16;
		is_call = (g == frost_isa_pkg::GRP_JUMP) && (op == frost_isa_pkg::OP_CALLNE
			|| op == frost_isa_pkg::OP_CALLEQ);
		if (g == frost_isa_pkg::GRP_IMM)
			ne = (op == frost_isa_pkg::OP_BNE);
		else
			ne = (op == frost_isa_pkg::OP_JNE) || (op == frost_isa_pkg::OP_CALLNE);
		taken = ne ? (model[ra] != model[rb]) : (model[ra] == model[rb]);
		if (g == frost_isa_pkg::GRP_IMM)
			emit(encode(g, op, ra, rb, 16'd12));
		else
			emit(encode(g, op, ra, rb, {4'd6, 12'h0}));
		redirect_tbl[(p - RESET_VECTOR) >> 2] = taken ? target : p + 32'd4;
		emit_spaced(encode(4'd1, frost_isa_pkg::OP_ADDI, 4'd5, 4'd5, 16'd1));
		model[5] = taken ? 32'd0 : 32'd1;
		if (is_call && taken)
			model[ra] = p + 32'd4;
		store_reg(4'd5);
		if (is_call)
			store_reg(ra);
	endtask

	task automatic build_program();
		logic [15:0] imm;
		logic [31:0] p;
		set_reg(4'd13, STORE_BASE[15:0]);
		rng = xorshift32(rng);
		load_reg(4'd1, rng);
		rng = xorshift32(rng);
		load_reg(4'd2, rng);
		// register group, r4 = r1 op r2
		for (int op = 0; op < 8; op++)
		begin
			emit_spaced(encode(4'd0, 4'(op), 4'd4, 4'd1, {4'd2, 12'h0}));
			model[4] = expected_alu(op, model[1], model[2]);
			store_reg(4'd4);
		end
		rng = xorshift32(rng);
		imm = rng[15:0];
		emit_spaced(encode(4'd1, frost_isa_pkg::OP_ADDI, 4'd4, 4'd1, imm));
		model[4] = model[1] + {16'h0, imm};
		store_reg(4'd4);
		emit_spaced(encode(4'd1, frost_isa_pkg::OP_ORI, 4'd4, 4'd1, imm));
		model[4] = model[1] | {16'h0, imm};
		store_reg(4'd4);
		rng = xorshift32(rng);
		imm = rng[31:16];
		emit_spaced(encode(4'd1, frost_isa_pkg::OP_SLTSI, 4'd4, 4'd1, imm));
		model[4] = ($signed(model[1]) < $signed(sext16(imm))) ? 32'd1 : 32'd0;
		store_reg(4'd4);
		p = pc_emit;
		emit_spaced(encode(4'd1, frost_isa_pkg::OP_ADDSI, 4'd4, 4'd0, imm));
		model[4] = p + sext16(imm);
		store_reg(4'd4);
		emit_spaced(encode(4'd1, frost_isa_pkg::OP_CPYHI, 4'd4, 4'd0, rng[15:0]));
		model[4] = {rng[15:0], model[4][15:0]};
		store_reg(4'd4);
		// branches and jumps, each condition both ways
		cond_flow(frost_isa_pkg::GRP_IMM, frost_isa_pkg::OP_BEQ, 4'd1, 4'd1);
		cond_flow(frost_isa_pkg::GRP_IMM, frost_isa_pkg::OP_BEQ, 4'd1, 4'd2);
		cond_flow(frost_isa_pkg::GRP_IMM, frost_isa_pkg::OP_BNE, 4'd1, 4'd2);
		cond_flow(frost_isa_pkg::GRP_IMM, frost_isa_pkg::OP_BNE, 4'd2, 4'd2);
		cond_flow(frost_isa_pkg::GRP_JUMP, frost_isa_pkg::OP_JEQ, 4'd1, 4'd1);
		cond_flow(frost_isa_pkg::GRP_JUMP, frost_isa_pkg::OP_JEQ, 4'd1, 4'd2);
		cond_flow(frost_isa_pkg::GRP_JUMP, frost_isa_pkg::OP_JNE, 4'd1, 4'd2);
		cond_flow(frost_isa_pkg::GRP_JUMP, frost_isa_pkg::OP_JNE, 4'd1, 4'd1);
		// calls link into r7, which is also the compared register
		load_reg(4'd7, model[1]);
		cond_flow(frost_isa_pkg::GRP_JUMP, frost_isa_pkg::OP_CALLEQ, 4'd7, 4'd1);
		cond_flow(frost_isa_pkg::GRP_JUMP, frost_isa_pkg::OP_CALLNE, 4'd7, 4'd1);
		cond_flow(frost_isa_pkg::GRP_JUMP, frost_isa_pkg::OP_CALLEQ, 4'd7, 4'd1);
		cond_flow(frost_isa_pkg::GRP_JUMP, frost_isa_pkg::OP_CALLNE, 4'd7, 4'd7);
		// final marker store, then spin on a jump to itself
		set_reg(4'd8, 16'h0d0e);
		done_slot = next_slot;
		store_reg(4'd8);
		set_reg(4'd9, 16'(pc_emit + 32'd12));
		p = pc_emit;
		emit(encode(frost_isa_pkg::GRP_JUMP, frost_isa_pkg::OP_JEQ, 4'd0, 4'd0, {4'd9, 12'h0}));
		redirect_tbl[(p - RESET_VECTOR) >> 2] = p;
	endtask

	initial
	begin
		int cyc;
		rst_n = 1'b0;
		rng = 32'hfabce4cf;
		prog_len = 0;
		next_slot = 0;
		mismatch_count = 0;
		assert_count = 0;
		other_count = 0;
		pc_emit = RESET_VECTOR;
		for (int i = 0; i < SLOTS; i++)
		begin
			exp_valid[i] = 1'b0;
			seen[i] = 1'b0;
			exp_store[i] = '0;
		end
		for (int i = 0; i < PROG_WORDS; i++)
			redirect_tbl[i] = '0;
		model[0] = '0;
		build_program();
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		cyc = 0;
		while (!seen[done_slot] && cyc < TIMEOUT)
		begin
			@(posedge clk);
			cyc++;
		end
		if (!seen[done_slot])
		begin
			other_count++;
			$display("timeout waiting for the final store");
		end
		for (int i = 0; i < SLOTS; i++)
		begin
			if (exp_valid[i] && !seen[i])
			begin
				other_count++;
				$display("expected store to %h never happened", STORE_BASE + 32'(i * 4));
			end
		end
		$display("errors: %0d mismatches, %0d assertions, %0d other",
			mismatch_count, assert_count, other_count);
		if (mismatch_count == 0 && assert_count == 0 && other_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule
